// File: logic/csa_pkg.sv
package csa_pkg;

	localparam int IN_WIDTH = 32;
	localparam int OP_WIDTH = 40;
	localparam int SUM_WIDTH = 43;
	localparam int GROUP_OPS = 4;
	localparam int WORDS_PER_GROUP = 5;

	typedef enum logic [3:0] {
		REG_CTRL = 4'h0,
		REG_BIAS = 4'h4,
		REG_COUNT = 4'h8
	} csa_reg_e;

	typedef enum logic [1:0] {
		SER_IDLE,
		SER_LOW,
		SER_HIGH
	} ser_state_e;

	// Operand 0 sits in the low bits
	typedef logic [GROUP_OPS-1:0][OP_WIDTH-1:0] csa_group_t;

	typedef struct packed {
		logic enable;
		logic clear;                  // One cycle pulse
		logic [IN_WIDTH-1:0] bias;
	} csa_ctrl_t;

	typedef struct packed {
		logic valid;
		logic [SUM_WIDTH-1:0] sum;
	} csa_sum_t;

endpackage

// File: logic/csa_regs.sv
module csa_regs
(
	input  logic aclk,
	input  logic rst_n,
	input  logic [3:0] s_axil_awaddr,
	input  logic s_axil_awvalid,
	output logic s_axil_awready,
	input  logic [csa_pkg::IN_WIDTH-1:0] s_axil_wdata,
	input  logic [csa_pkg::IN_WIDTH/8-1:0] s_axil_wstrb,
	input  logic s_axil_wvalid,
	output logic s_axil_wready,
	output logic [1:0] s_axil_bresp,
	output logic s_axil_bvalid,
	input  logic s_axil_bready,
	input  logic [3:0] s_axil_araddr,
	input  logic s_axil_arvalid,
	output logic s_axil_arready,
	output logic [csa_pkg::IN_WIDTH-1:0] s_axil_rdata,
	output logic [1:0] s_axil_rresp,
	output logic s_axil_rvalid,
	input  logic s_axil_rready,
	output csa_pkg::csa_ctrl_t ctrl,
	input  logic sum_done
);
	import csa_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	csa_ctrl_t ctrl_q;
	logic [IN_WIDTH-1:0] count;
	logic wr_en;
	logic rd_en;
	csa_reg_e waddr;
	csa_reg_e raddr;

	assign wr_en = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;  // AW and W taken together
	assign rd_en = s_axil_arvalid && s_axil_arready;
	assign s_axil_awready = wr_en;
	assign s_axil_wready = wr_en;
	assign s_axil_arready = !s_axil_rvalid;
	assign waddr = csa_reg_e'(s_axil_awaddr);
	assign raddr = csa_reg_e'(s_axil_araddr);
	assign ctrl = ctrl_q;

	always_ff @(posedge aclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ctrl_q <= '0;
			count <= '0;
			s_axil_bvalid <= 1'b0;
			s_axil_rvalid <= 1'b0;
		end
		else
		begin
			ctrl_q.clear <= 1'b0;
			if (wr_en && waddr == REG_CTRL && s_axil_wstrb[0])
			begin
				ctrl_q.enable <= s_axil_wdata[0];
				ctrl_q.clear <= s_axil_wdata[1];
			end
			if (wr_en && waddr == REG_BIAS)
			begin
				for (int i = 0; i < IN_WIDTH / 8; i++)
					if (s_axil_wstrb[i])
						ctrl_q.bias[8*i +: 8] <= s_axil_wdata[8*i +: 8];
			end
			if (ctrl_q.clear)
				count <= '0;                                     // Clear beats a late sum_done
			else if (sum_done)
				count <= count + 1'b1;
			if (wr_en)
				s_axil_bvalid <= 1'b1;
			else if (s_axil_bready)
				s_axil_bvalid <= 1'b0;
			if (rd_en)
				s_axil_rvalid <= 1'b1;
			else if (s_axil_rready)
				s_axil_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (wr_en)
			s_axil_bresp <= (waddr inside {REG_CTRL, REG_BIAS, REG_COUNT}) ? RESP_OKAY : RESP_SLVERR;
		if (rd_en)
		begin
			s_axil_rresp <= RESP_OKAY;
			case (raddr)
				REG_CTRL:
					s_axil_rdata <= {{(IN_WIDTH-1){1'b0}}, ctrl_q.enable};  // Clear bit reads 0
				REG_BIAS:
					s_axil_rdata <= ctrl_q.bias;
				REG_COUNT:
					s_axil_rdata <= count;
				default:
				begin
					s_axil_rdata <= '0;
					s_axil_rresp <= RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

// File: logic/word_repack.sv
module word_repack
(
	input  logic aclk,
	input  logic rst_n,
	input  csa_pkg::csa_ctrl_t ctrl,
	input  logic [csa_pkg::IN_WIDTH-1:0] s_axis_tdata,
	input  logic s_axis_tvalid,
	output logic s_axis_tready,
	output csa_pkg::csa_group_t group,
	output logic group_valid,
	input  logic group_ready
);
	import csa_pkg::*;

	localparam int BUF_WIDTH = GROUP_OPS * OP_WIDTH;  // Same as five input words

	logic [BUF_WIDTH-1:0] buffer;
	logic [2:0] word_cnt;
	logic take;

	assign s_axis_tready = ctrl.enable && !group_valid;
	assign take = s_axis_tvalid && s_axis_tready;
	assign group = csa_group_t'(buffer);

	// New words enter at the top so the first one ends up in bits 31:0
	always_ff @(posedge aclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			buffer <= '0;
			word_cnt <= '0;
			group_valid <= 1'b0;
		end
		else if (ctrl.clear)
		begin
			buffer <= '0;
			word_cnt <= '0;
			group_valid <= 1'b0;
		end
		else
		begin
			if (take)
			begin
				buffer <= {s_axis_tdata, buffer[BUF_WIDTH-1:IN_WIDTH]};
				if (word_cnt == 3'(WORDS_PER_GROUP - 1))
				begin
					word_cnt <= '0;
					group_valid <= 1'b1;
				end
				else
					word_cnt <= word_cnt + 1'b1;
			end
			if (group_valid && group_ready)
				group_valid <= 1'b0;                     // Input is held off until here
		end
	end

endmodule

// File: logic/csa_tree.sv
module csa_tree
(
	input  logic aclk,
	input  logic rst_n,
	input  csa_pkg::csa_ctrl_t ctrl,
	input  csa_pkg::csa_group_t group,
	input  logic group_valid,
	output logic group_ready,
	output csa_pkg::csa_sum_t sum,
	input  logic sum_ready
);
	import csa_pkg::*;

	logic advance;
	logic s1_valid;
	logic s2_valid;
	logic s3_valid;
	logic [SUM_WIDTH-1:0] c1_sum, c1_carry;
	logic [SUM_WIDTH-1:0] s1_sum, s1_carry, s1_op3, s1_bias;
	logic [SUM_WIDTH-1:0] t_sum, t_carry, r_sum, r_carry;
	logic [SUM_WIDTH-1:0] s2_sum, s2_carry;
	logic [SUM_WIDTH-1:0] s3_sum;

	// 3:2 compressor, returns {carry, sum}
	function automatic logic [2*SUM_WIDTH-1:0] csa32(input logic [SUM_WIDTH-1:0] x,
		input logic [SUM_WIDTH-1:0] y, input logic [SUM_WIDTH-1:0] z);
		logic [SUM_WIDTH-1:0] s;
		logic [SUM_WIDTH-1:0] c;
		s = x ^ y ^ z;
		c = ((x & y) | (x & z) | (y & z)) << 1;
		return {c, s};
	endfunction

	assign advance = !s3_valid || sum_ready;  // Whole pipe moves as one
	assign group_ready = advance;

	assign {c1_carry, c1_sum} = csa32(SUM_WIDTH'(group[0]), SUM_WIDTH'(group[1]),
		SUM_WIDTH'(group[2]));
	assign {t_carry, t_sum} = csa32(s1_sum, s1_carry, s1_op3);  // 4:2 as two 3:2 steps
	assign {r_carry, r_sum} = csa32(t_sum, t_carry, s1_bias);

	assign sum = csa_sum_t'{valid: s3_valid, sum: s3_sum};

	always_ff @(posedge aclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
		end
		else if (ctrl.clear)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
		end
		else if (advance)
		begin
			s1_valid <= group_valid;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (advance)
		begin
			s1_sum <= c1_sum;
			s1_carry <= c1_carry;
			s1_op3 <= SUM_WIDTH'(group[3]);
			s1_bias <= SUM_WIDTH'(ctrl.bias);         // Bias taken at acceptance
			s2_sum <= r_sum;
			s2_carry <= r_carry;
			s3_sum <= s2_sum + s2_carry;
		end
	end

endmodule

// File: logic/result_serializer.sv
module result_serializer
(
	input  logic aclk,
	input  logic rst_n,
	input  csa_pkg::csa_ctrl_t ctrl,
	input  csa_pkg::csa_sum_t sum,
	output logic sum_ready,
	output logic [csa_pkg::IN_WIDTH-1:0] m_axis_tdata,
	output logic m_axis_tvalid,
	output logic m_axis_tlast,
	input  logic m_axis_tready,
	output logic sum_done
);
	import csa_pkg::*;

	ser_state_e state;
	logic [SUM_WIDTH-1:0] hold;

	assign sum_ready = (state == SER_IDLE);
	assign m_axis_tvalid = (state != SER_IDLE);
	assign m_axis_tlast = (state == SER_HIGH);
	assign m_axis_tdata = m_axis_tlast ? IN_WIDTH'(hold[SUM_WIDTH-1:IN_WIDTH])
		: hold[IN_WIDTH-1:0];
	assign sum_done = m_axis_tlast && m_axis_tready;

	always_ff @(posedge aclk or negedge rst_n)
	begin
		if (!rst_n)
			state <= SER_IDLE;
		else if (ctrl.clear)
			state <= SER_IDLE;
		else
		begin
			case (state)
				SER_IDLE:
					if (sum.valid)
						state <= SER_LOW;
				SER_LOW:
					if (m_axis_tready)
						state <= SER_HIGH;
				SER_HIGH:
					if (m_axis_tready)
						state <= SER_IDLE;
				default:
					state <= SER_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk)
	begin
		if (sum_ready && sum.valid)
			hold <= sum.sum;
	end

endmodule

// File: logic/csa_top.sv
module csa_top
(
	input  logic aclk,
	input  logic rst_n,
	input  logic [3:0] s_axil_awaddr,
	input  logic s_axil_awvalid,
	output logic s_axil_awready,
	input  logic [csa_pkg::IN_WIDTH-1:0] s_axil_wdata,
	input  logic [csa_pkg::IN_WIDTH/8-1:0] s_axil_wstrb,
	input  logic s_axil_wvalid,
	output logic s_axil_wready,
	output logic [1:0] s_axil_bresp,
	output logic s_axil_bvalid,
	input  logic s_axil_bready,
	input  logic [3:0] s_axil_araddr,
	input  logic s_axil_arvalid,
	output logic s_axil_arready,
	output logic [csa_pkg::IN_WIDTH-1:0] s_axil_rdata,
	output logic [1:0] s_axil_rresp,
	output logic s_axil_rvalid,
	input  logic s_axil_rready,
	input  logic [csa_pkg::IN_WIDTH-1:0] s_axis_tdata,
	input  logic s_axis_tvalid,
	output logic s_axis_tready,
	output logic [csa_pkg::IN_WIDTH-1:0] m_axis_tdata,
	output logic m_axis_tvalid,
	input  logic m_axis_tready,
	output logic m_axis_tlast
);
	import csa_pkg::*;

	csa_ctrl_t ctrl;
	csa_group_t group;
	csa_sum_t sum;
	logic group_valid;
	logic group_ready;
	logic sum_ready;
	logic sum_done;

	csa_regs u_regs (
		.aclk(aclk), .rst_n(rst_n),
		.s_axil_awaddr(s_axil_awaddr), .s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_wdata(s_axil_wdata), .s_axil_wstrb(s_axil_wstrb),
		.s_axil_wvalid(s_axil_wvalid), .s_axil_wready(s_axil_wready),
		.s_axil_bresp(s_axil_bresp), .s_axil_bvalid(s_axil_bvalid),
		.s_axil_bready(s_axil_bready),
		.s_axil_araddr(s_axil_araddr), .s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
		.s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
		.ctrl(ctrl), .sum_done(sum_done)
	);

	word_repack u_repack (
		.aclk(aclk), .rst_n(rst_n), .ctrl(ctrl),
		.s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready),
		.group(group), .group_valid(group_valid), .group_ready(group_ready)
	);

	csa_tree u_tree (
		.aclk(aclk), .rst_n(rst_n), .ctrl(ctrl),
		.group(group), .group_valid(group_valid), .group_ready(group_ready),
		.sum(sum), .sum_ready(sum_ready)
	);

	result_serializer u_ser (
		.aclk(aclk), .rst_n(rst_n), .ctrl(ctrl),
		.sum(sum), .sum_ready(sum_ready),
		.m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
		.m_axis_tlast(m_axis_tlast), .m_axis_tready(m_axis_tready),
		.sum_done(sum_done)
	);

endmodule

// File: dv/csa_checker.sv
module csa_checker
(
	input  logic aclk,
	input  logic rst_n,
	input  logic [csa_pkg::IN_WIDTH-1:0] m_axis_tdata,
	input  logic m_axis_tvalid,
	input  logic m_axis_tready,
	input  logic m_axis_tlast,
	output int errors,
	output int results
);
	import csa_pkg::*;

	logic [SUM_WIDTH-1:0] exp_q[$];
	logic high_beat;
	logic [SUM_WIDTH-1:0] exp_sum;
	logic [IN_WIDTH-1:0] exp_data;

	task automatic add_expected(input logic [SUM_WIDTH-1:0] value);
		exp_q.push_back(value);
	endtask

	initial
	begin
		errors = 0;
		results = 0;
		high_beat = 1'b0;
	end

	// One sum is two beats, low word first
	always @(posedge aclk)
	begin
		if (rst_n && m_axis_tvalid && m_axis_tready)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Output beat arrived while no sum was expected");
				errors++;
			end
			else
			begin
				exp_sum = exp_q[0];
				if (high_beat)
					exp_data = IN_WIDTH'(exp_sum[SUM_WIDTH-1:IN_WIDTH]);
				else
					exp_data = exp_sum[IN_WIDTH-1:0];
				if (m_axis_tdata !== exp_data)
				begin
					$display("FAIL m_axis_tdata: got %h expected %h", m_axis_tdata, exp_data);
					errors++;
				end
				if (m_axis_tlast !== high_beat)
				begin
					$display("FAIL m_axis_tlast: got %h expected %h", m_axis_tlast, high_beat);
					errors++;
				end
				if (high_beat)
				begin
					void'(exp_q.pop_front());
					results++;
				end
				high_beat = !high_beat;
			end
		end
	end

endmodule

// File: dv/csa_assert.sv
module csa_assert
(
	input  logic aclk,
	input  logic rst_n,
	input  logic [csa_pkg::IN_WIDTH-1:0] m_axis_tdata,
	input  logic m_axis_tvalid,
	input  logic m_axis_tready,
	input  logic m_axis_tlast,
	input  logic s_axil_bvalid,
	input  logic s_axil_rvalid
);
	int fail_count = 0;

	valid_held: assert property (@(posedge aclk) disable iff (!rst_n)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid)
	else
	begin
		$error("m_axis_tvalid dropped before the beat was taken");
		fail_count++;
	end

	data_held: assert property (@(posedge aclk) disable iff (!rst_n)
		m_axis_tvalid && !m_axis_tready |=> $stable(m_axis_tdata) && $stable(m_axis_tlast))
	else
	begin
		$error("m_axis_tdata or m_axis_tlast changed during a stall");
		fail_count++;
	end

	quiet_in_reset: assert property (@(posedge aclk)
		!rst_n |-> !s_axil_bvalid && !s_axil_rvalid)
	else
	begin
		$error("AXI4-Lite response valid high during reset");
		fail_count++;
	end

endmodule

bind csa_top csa_assert u_assert (
	.aclk(aclk), .rst_n(rst_n),
	.m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
	.m_axis_tready(m_axis_tready), .m_axis_tlast(m_axis_tlast),
	.s_axil_bvalid(s_axil_bvalid), .s_axil_rvalid(s_axil_rvalid)
);

// File: dv/csa_tb.sv
module csa_tb;
	import csa_pkg::*;

	localparam int NUM_GROUPS = 45;                     // 20 + 4 + 20 + 1
	localparam int TIMEOUT_CYCLES = 200 * NUM_GROUPS + 1000;

	logic aclk;
	logic rst_n;
	logic [3:0] s_axil_awaddr;
	logic s_axil_awvalid;
	logic s_axil_awready;
	logic [IN_WIDTH-1:0] s_axil_wdata;
	logic [IN_WIDTH/8-1:0] s_axil_wstrb;
	logic s_axil_wvalid;
	logic s_axil_wready;
	logic [1:0] s_axil_bresp;
	logic s_axil_bvalid;
	logic s_axil_bready;
	logic [3:0] s_axil_araddr;
	logic s_axil_arvalid;
	logic s_axil_arready;
	logic [IN_WIDTH-1:0] s_axil_rdata;
	logic [1:0] s_axil_rresp;
	logic s_axil_rvalid;
	logic s_axil_rready;
	logic [IN_WIDTH-1:0] s_axis_tdata;
	logic s_axis_tvalid;
	logic s_axis_tready;
	logic [IN_WIDTH-1:0] m_axis_tdata;
	logic m_axis_tvalid;
	logic m_axis_tready;
	logic m_axis_tlast;
	int tb_errors;
	int chk_errors;
	int chk_results;
	logic [31:0] data_state;
	logic [31:0] gap_state;
	logic [IN_WIDTH-1:0] bias;
	logic backpressure;
	logic ready_seen;
	logic [IN_WIDTH-1:0] rd_data;
	logic [1:0] resp;

	csa_top u_dut (.*);

	csa_checker u_chk (
		.aclk(aclk), .rst_n(rst_n),
		.m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready), .m_axis_tlast(m_axis_tlast),
		.errors(chk_errors), .results(chk_results)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Five words little-endian, cut into four 40-bit operands
	function automatic logic [SUM_WIDTH-1:0] ref_sum(input logic [5*IN_WIDTH-1:0] words,
		input logic [IN_WIDTH-1:0] bias_val);
		logic [SUM_WIDTH-1:0] acc;
		acc = SUM_WIDTH'(bias_val);
		for (int i = 0; i < GROUP_OPS; i++)
			acc = acc + SUM_WIDTH'(words[OP_WIDTH*i +: OP_WIDTH]);
		return acc;
	endfunction

	function automatic logic [31:0] apply_strobe(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] merged;
		merged = old_val;
		for (int i = 0; i < 4; i++)
			if (strb[i])
				merged[8*i +: 8] = new_val[8*i +: 8];
		return merged;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			tb_errors++;
		end
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] bresp);
		@(negedge aclk);
		s_axil_awaddr = addr;
		s_axil_wdata = data;
		s_axil_wstrb = strb;
		s_axil_awvalid = 1'b1;
		s_axil_wvalid = 1'b1;
		@(posedge aclk);
		while (!(s_axil_awready && s_axil_wready))
			@(posedge aclk);
		@(negedge aclk);
		s_axil_awvalid = 1'b0;
		s_axil_wvalid = 1'b0;
		s_axil_bready = 1'b1;
		@(posedge aclk);
		while (!s_axil_bvalid)
			@(posedge aclk);
		bresp = s_axil_bresp;
		@(negedge aclk);
		s_axil_bready = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] rresp);
		@(negedge aclk);
		s_axil_araddr = addr;
		s_axil_arvalid = 1'b1;
		s_axil_rready = 1'b1;
		@(posedge aclk);
		while (!s_axil_arready)
			@(posedge aclk);
		@(negedge aclk);
		s_axil_arvalid = 1'b0;
		@(posedge aclk);
		while (!s_axil_rvalid)
			@(posedge aclk);
		data = s_axil_rdata;
		rresp = s_axil_rresp;
		@(negedge aclk);
		s_axil_rready = 1'b0;
	endtask

	task automatic send_word(input logic [IN_WIDTH-1:0] word);
		@(negedge aclk);
		s_axis_tdata = word;
		s_axis_tvalid = 1'b1;
		@(posedge aclk);
		while (!s_axis_tready)
			@(posedge aclk);
	endtask

	task automatic send_group(input logic change_bias);
		logic [5*IN_WIDTH-1:0] words;
		logic [1:0] wr_resp;
		for (int i = 0; i < WORDS_PER_GROUP; i++)
		begin
			data_state = lcg_next(data_state);
			words[IN_WIDTH*i +: IN_WIDTH] = data_state;
		end
		for (int i = 0; i < WORDS_PER_GROUP; i++)
		begin
			if (change_bias && i == WORDS_PER_GROUP - 1)
			begin
				@(negedge aclk);
				s_axis_tvalid = 1'b0;                // Hold the last word back
				data_state = lcg_next(data_state);
				bias = data_state;
				write_reg(REG_BIAS, bias, 4'hF, wr_resp);
				check_eq("s_axil_bresp", 32'(wr_resp), 32'h0);
			end
			send_word(words[IN_WIDTH*i +: IN_WIDTH]);
		end
		@(negedge aclk);
		s_axis_tvalid = 1'b0;
		u_chk.add_expected(ref_sum(words, bias));
	endtask

	task automatic wait_results(input int count);
		while (chk_results < count)
			@(negedge aclk);
	endtask

	initial
	begin
		aclk = 1'b0;
		forever
			#4 aclk = ~aclk;
	end

	// Output gaps, only while back-pressure is on
	initial
	begin
		m_axis_tready = 1'b1;
		gap_state = 32'd33;
		forever
		begin
			@(negedge aclk);
			gap_state = lcg_next(gap_state);
			m_axis_tready = !backpressure || (gap_state[31:30] != 2'b00);
		end
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge aclk);
		$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		tb_errors = 0;
		data_state = 32'd33;
		bias = '0;
		backpressure = 1'b0;
		ready_seen = 1'b0;
		rst_n = 1'b0;
		s_axil_awaddr = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata = '0;
		s_axil_wstrb = '0;
		s_axil_wvalid = 1'b0;
		s_axil_bready = 1'b0;
		s_axil_araddr = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready = 1'b0;
		s_axis_tdata = '0;
		s_axis_tvalid = 1'b0;
		repeat (4) @(posedge aclk);
		@(negedge aclk);
		rst_n = 1'b1;

		write_reg(REG_BIAS, 32'h1234_5678, 4'hF, resp);
		check_eq("s_axil_bresp", 32'(resp), 32'h0);
		read_reg(REG_BIAS, rd_data, resp);
		check_eq("s_axil_rdata (BIAS)", rd_data, 32'h1234_5678);
		write_reg(REG_BIAS, 32'hAABB_CCDD, 4'b0101, resp);
		bias = apply_strobe(32'h1234_5678, 32'hAABB_CCDD, 4'b0101);
		read_reg(REG_BIAS, rd_data, resp);
		check_eq("s_axil_rdata (BIAS)", rd_data, bias);
		check_eq("s_axil_rresp", 32'(resp), 32'h0);
		write_reg(REG_CTRL, 32'h1, 4'hF, resp);
		read_reg(REG_CTRL, rd_data, resp);
		check_eq("s_axil_rdata (CTRL)", rd_data, 32'h1);
		write_reg(REG_CTRL, 32'h0, 4'hF, resp);
		read_reg(REG_CTRL, rd_data, resp);
		check_eq("s_axil_rdata (CTRL)", rd_data, 32'h0);
		write_reg(4'hC, 32'hFFFF_FFFF, 4'hF, resp);     // Unmapped
		check_eq("s_axil_bresp", 32'(resp), 32'h2);
		read_reg(4'hC, rd_data, resp);
		check_eq("s_axil_rresp", 32'(resp), 32'h2);

		repeat (16)
		begin
			@(posedge aclk);
			if (s_axis_tready)
				ready_seen = 1'b1;
		end
		if (ready_seen)
		begin
			$display("s_axis_tready went high while the block was disabled");
			tb_errors++;
		end

		write_reg(REG_CTRL, 32'h1, 4'hF, resp);
		repeat (20) send_group(1'b0);
		wait_results(20);
		repeat (4) send_group(1'b1);
		wait_results(24);

		backpressure = 1'b1;
		repeat (20) send_group(1'b0);
		wait_results(44);
		backpressure = 1'b0;
		read_reg(REG_COUNT, rd_data, resp);
		check_eq("s_axil_rdata (COUNT)", rd_data, 32'd44);

		// Two words of a group, then clear
		data_state = lcg_next(data_state);
		send_word(data_state);
		data_state = lcg_next(data_state);
		send_word(data_state);
		@(negedge aclk);
		s_axis_tvalid = 1'b0;
		write_reg(REG_CTRL, 32'h3, 4'hF, resp);
		read_reg(REG_COUNT, rd_data, resp);
		check_eq("s_axil_rdata (COUNT)", rd_data, 32'd0);
		send_group(1'b0);
		wait_results(45);
		read_reg(REG_COUNT, rd_data, resp);
		check_eq("s_axil_rdata (COUNT)", rd_data, 32'd1);
		repeat (20) @(negedge aclk);                   // Room for a stray beat

		$display("Errors: testbench %0d, checker %0d, assertions %0d, results %0d",
			tb_errors, chk_errors, u_dut.u_assert.fail_count, chk_results);
		if (tb_errors + chk_errors + u_dut.u_assert.fail_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: filelist.f
logic/csa_pkg.sv
logic/csa_regs.sv
logic/word_repack.sv
logic/csa_tree.sv
logic/result_serializer.sv
logic/csa_top.sv
dv/csa_checker.sv
dv/csa_assert.sv
dv/csa_tb.sv

// File: Bender.yml
package:
  name: csa_accel

sources:
  - logic/csa_pkg.sv
  - logic/csa_regs.sv
  - logic/word_repack.sv
  - logic/csa_tree.sv
  - logic/result_serializer.sv
  - logic/csa_top.sv
  - target: test
    files:
      - dv/csa_checker.sv
      - dv/csa_assert.sv
      - dv/csa_tb.sv
